/* vlog.f */
common/bridge_pkg.sv
logic/sram_port_mux.sv
bridge/axi_read_path.sv
bridge/axi_write_path.sv
bridge/cpu_axi_bridge.sv
test/axi_slave_model.sv
test/bridge_chk.sv
test/tb_cpu_axi_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_axi_bridge
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# exit status of the simulation binary is the test result
sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_cpu_axi_bridge.sv */
`default_nettype none

module tb_cpu_axi_bridge
    import bridge_pkg::*;
();

    localparam int NUM_OPS     = 300;
    localparam int TXN_TIMEOUT = 200;
    localparam int RUN_TIMEOUT = 50000;

    logic      clk;
    logic      resetn;
    logic      inst_req = 1'b0;
    sram_req_t inst_sram = '0;
    logic      inst_addr_ok;
    logic      inst_data_ok;
    data_t     inst_rdata;
    logic      data_req = 1'b0;
    sram_req_t data_sram = '0;
    logic      data_addr_ok;
    logic      data_data_ok;
    data_t     data_rdata;
    axi_a_t    ar;
    logic      arvalid;
    logic      arready;
    axi_r_t    r;
    logic      rvalid;
    logic      rready;
    axi_a_t    aw;
    logic      awvalid;
    logic      awready;
    axi_w_t    w;
    logic      wvalid;
    logic      wready;
    logic      bvalid;
    logic      bready;

    // reference memory and expected responses per port
    data_t       ref_mem [256];
    data_t       inst_q [$];
    logic [32:0] data_q [$];
    axi_a_t      ar_q [$];
    axi_a_t      aw_q [$];
    axi_w_t      w_q [$];
    logic [31:0] rnd = 32'd31628;
    int          inst_issued = 0;
    int          inst_done = 0;
    int          data_issued = 0;
    int          data_done = 0;
    int          same_cycle_reads = 0;
    int          inst_age = 0;
    int          data_age = 0;

    cpu_axi_bridge dut (.*);

    axi_slave_model u_slave (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_error(input string why);
        $display("ERROR: %s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // instruction fetches stay in words 0..127, never written
    task automatic next_inst_request();
        rnd = xorshift32(rnd);
        inst_req  <= (rnd[1:0] != 2'b00) && (inst_issued < NUM_OPS);
        inst_sram <= '{wr: 1'b0, size: 2'd2, wstrb: '0,
                       addr: {23'd0, rnd[14:8], 2'b00}, wdata: '0};
    endtask

    // writes go to a 32-word window in the upper half, reads mostly hit it
    task automatic next_data_request();
        logic [7:0] word;
        rnd = xorshift32(rnd);
        word = rnd[3] ? {3'b100, rnd[12:8]} : rnd[15:8];
        data_req <= (rnd[1:0] != 2'b00) && (data_issued < NUM_OPS);
        if (rnd[2]) begin
            data_sram <= '{wr: 1'b1, size: 2'd2, wstrb: rnd[19:16],
                           addr: {22'd0, 3'b100, rnd[12:8], 2'b00},
                           wdata: xorshift32(rnd ^ 32'h5a5a_0f0f)};
        end else begin
            data_sram <= '{wr: 1'b0, size: 2'd2, wstrb: '0,
                           addr: {22'd0, word, 2'b00}, wdata: '0};
        end
    endtask

    always @(posedge clk) begin
        logic [32:0] dexp;
        axi_a_t      aexp;
        axi_w_t      wexp;
        int          idx;
        if (!resetn) begin
            for (int i = 0; i < 256; i++) begin
                ref_mem[i] = u_slave.mem[i];
            end
        end else if (dut.u_chk.fail_count != 0) begin
            report_error("an assertion in bridge_chk failed");
        end else if (inst_age > TXN_TIMEOUT) begin
            report_error("instruction read did not complete in time");
        end else if (data_age > TXN_TIMEOUT) begin
            report_error("data request did not complete in time");
        end else begin
            if (inst_data_ok) begin
                if (inst_q.size() == 0) begin
                    report_error("inst_data_ok with no instruction read outstanding");
                end else begin
                    check_value("instruction read", inst_q.pop_front(), inst_rdata);
                    inst_done++;
                end
            end
            if (data_data_ok) begin
                if (data_q.size() == 0) begin
                    report_error("data_data_ok with no data request outstanding");
                end else begin
                    dexp = data_q.pop_front();
                    if (!dexp[32]) begin
                        check_value("data read", dexp[31:0], data_rdata);
                    end
                    data_done++;
                end
            end
            // AR beats must leave in acceptance order, instruction first
            if (arvalid && arready) begin
                if (ar_q.size() == 0) begin
                    report_error("AR beat without an accepted read");
                end else begin
                    aexp = ar_q.pop_front();
                    check_value("ar id", 32'(aexp.id), 32'(ar.id));
                    check_value("ar addr", aexp.addr, ar.addr);
                    check_value("ar size", 32'(aexp.size), 32'(ar.size));
                end
            end
            // one AW and one W per accepted write
            if (awvalid && awready) begin
                if (aw_q.size() == 0) begin
                    report_error("AW beat without an accepted write");
                end else begin
                    aexp = aw_q.pop_front();
                    check_value("aw addr", aexp.addr, aw.addr);
                    check_value("aw size", 32'(aexp.size), 32'(aw.size));
                end
            end
            if (wvalid && wready) begin
                if (w_q.size() == 0) begin
                    report_error("W beat without an accepted write");
                end else begin
                    wexp = w_q.pop_front();
                    check_value("w data", wexp.data, w.data);
                    check_value("w strb", 32'(wexp.strb), 32'(w.strb));
                end
            end
            if (inst_req && inst_addr_ok) begin
                inst_q.push_back(ref_mem[inst_sram.addr[9:2]]);
                ar_q.push_back('{id: ID_INST, addr: inst_sram.addr, size: 3'd2});
                inst_issued++;
            end
            if (data_req && data_addr_ok) begin
                idx = int'(data_sram.addr[9:2]);
                if (data_sram.wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (data_sram.wstrb[b]) begin
                            ref_mem[idx][8*b +: 8] = data_sram.wdata[8*b +: 8];
                        end
                    end
                    data_q.push_back({1'b1, 32'd0});
                    aw_q.push_back('{id: ID_DATA, addr: data_sram.addr, size: 3'd2});
                    w_q.push_back('{data: data_sram.wdata, strb: data_sram.wstrb});
                end else begin
                    data_q.push_back({1'b0, ref_mem[idx]});
                    ar_q.push_back('{id: ID_DATA, addr: data_sram.addr, size: 3'd2});
                    if (inst_req && inst_addr_ok) begin
                        same_cycle_reads++;
                    end
                end
                data_issued++;
            end
            inst_age = (inst_q.size() == 0 || inst_data_ok) ? 0 : inst_age + 1;
            data_age = (data_q.size() == 0 || data_data_ok) ? 0 : data_age + 1;
            if (!inst_req || inst_addr_ok) begin
                next_inst_request();
            end
            if (!data_req || data_addr_ok) begin
                next_data_request();
            end
        end
    end

    initial begin
        int cycles;
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_value("reset outputs low", 32'd0,
                    32'({arvalid, awvalid, wvalid, inst_data_ok, data_data_ok,
                         inst_addr_ok, data_addr_ok}));
        check_value("reset ready high", 32'd3, 32'({rready, bready}));
        cycles = 0;
        while (inst_done < NUM_OPS || data_done < NUM_OPS) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                report_error("timed out before all requests completed");
            end
        end
        if (same_cycle_reads == 0) begin
            report_error("no same-cycle instruction and data reads were seen");
        end else if (dut.u_chk.fail_count != 0) begin
            report_error("an assertion in bridge_chk failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/bridge_chk.sv */
`default_nettype none

module bridge_chk
    import bridge_pkg::*;
(
    input wire logic   clk,
    input wire logic   resetn,
    input wire logic   inst_addr_ok,
    input wire logic   inst_data_ok,
    input wire logic   data_addr_ok,
    input wire logic   data_data_ok,
    input wire axi_a_t ar,
    input wire logic   arvalid,
    input wire logic   arready,
    input wire axi_a_t aw,
    input wire logic   awvalid,
    input wire logic   awready,
    input wire axi_w_t w,
    input wire logic   wvalid,
    input wire logic   wready
);

    int   fail_count = 0;
    logic inst_open_q;
    logic data_open_q;

    // requests accepted and not yet answered
    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_open_q <= 1'b0;
            data_open_q <= 1'b0;
        end else begin
            if (inst_addr_ok) begin
                inst_open_q <= 1'b1;
            end else if (inst_data_ok) begin
                inst_open_q <= 1'b0;
            end
            if (data_addr_ok) begin
                data_open_q <= 1'b1;
            end else if (data_data_ok) begin
                data_open_q <= 1'b0;
            end
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!resetn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            fail_count++;
            $error("AR dropped or changed before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!resetn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            fail_count++;
            $error("AW dropped or changed before awready");
        end

    w_hold: assert property (@(posedge clk) disable iff (!resetn)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            fail_count++;
            $error("W dropped or changed before wready");
        end

    ok_needs_req: assert property (@(posedge clk) disable iff (!resetn)
        (!inst_data_ok || inst_open_q) && (!data_data_ok || data_open_q))
        else begin
            fail_count++;
            $error("data_ok without an outstanding request");
        end

endmodule

bind cpu_axi_bridge bridge_chk u_chk (.*);

`default_nettype wire

/* test/axi_slave_model.sv */
`default_nettype none

module axi_slave_model
    import bridge_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   resetn,
    input  wire axi_a_t ar,
    input  wire logic   arvalid,
    output logic        arready = 1'b0,
    output axi_r_t      r = '0,
    output logic        rvalid = 1'b0,
    input  wire logic   rready,
    input  wire axi_a_t aw,
    input  wire logic   awvalid,
    output logic        awready = 1'b0,
    input  wire axi_w_t w,
    input  wire logic   wvalid,
    output logic        wready = 1'b0,
    output logic        bvalid = 1'b0,
    input  wire logic   bready
);

    data_t       mem [256];
    logic        slot_v [4];
    axi_id_t     slot_id [4];
    addr_t       slot_addr [4];
    int          slot_wait [4];
    axi_a_t      aw_q;
    axi_w_t      w_q;
    logic        have_aw;
    logic        have_w;
    logic        b_pend;
    int          b_wait;
    logic [31:0] rnd = 32'd31628;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    always @(posedge clk) begin
        int k;
        int pick;
        rnd = xorshift32(rnd);
        if (!resetn) begin
            // memory contents depend on every address bit
            for (int i = 0; i < 256; i++) begin
                mem[i] = {8'(i) ^ 8'ha5, ~8'(i), 8'(i) + 8'h31, 8'(i * 7)};
            end
            for (int i = 0; i < 4; i++) begin
                slot_v[i] = 1'b0;
            end
            have_aw = 1'b0;
            have_w  = 1'b0;
            b_pend  = 1'b0;
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            arready <= rnd[1:0] != 2'b00;
            awready <= rnd[3:2] != 2'b00;
            wready  <= rnd[5:4] != 2'b00;
            for (int i = 0; i < 4; i++) begin
                if (slot_v[i] && slot_wait[i] > 0) begin
                    slot_wait[i]--;
                end
            end
            if (arvalid && arready) begin
                k = 0;
                while (k < 3 && slot_v[k]) begin
                    k++;
                end
                slot_v[k]    = 1'b1;
                slot_id[k]   = ar.id;
                slot_addr[k] = ar.addr;
                slot_wait[k] = int'(rnd[8:6]);
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (!rvalid) begin
                // random start slot, so a later read can overtake an earlier one
                pick = -1;
                for (int i = 0; i < 4; i++) begin
                    k = (i + int'(rnd[10:9])) % 4;
                    if (pick < 0 && slot_v[k] && slot_wait[k] == 0) begin
                        pick = k;
                    end
                end
                if (pick >= 0) begin
                    r      <= '{id: slot_id[pick], data: mem[slot_addr[pick][9:2]]};
                    rvalid <= 1'b1;
                    slot_v[pick] = 1'b0;
                end
            end
            if (awvalid && awready) begin
                aw_q    = aw;
                have_aw = 1'b1;
            end
            if (wvalid && wready) begin
                w_q    = w;
                have_w = 1'b1;
            end
            // write lands once both address and data are in
            if (have_aw && have_w) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_q.strb[b]) begin
                        mem[aw_q.addr[9:2]][8*b +: 8] = w_q.data[8*b +: 8];
                    end
                end
                have_aw = 1'b0;
                have_w  = 1'b0;
                b_pend  = 1'b1;
                b_wait  = int'(rnd[13:11]);
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pend) begin
                if (b_wait == 0) begin
                    bvalid <= 1'b1;
                    b_pend = 1'b0;
                end else begin
                    b_wait--;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bridge/cpu_axi_bridge.sv */
`default_nettype none

module cpu_axi_bridge
    import bridge_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      resetn,

    // instruction fetch port
    input  wire logic      inst_req,
    input  wire sram_req_t inst_sram,
    output logic           inst_addr_ok,
    output logic           inst_data_ok,
    output data_t          inst_rdata,

    // data access port
    input  wire logic      data_req,
    input  wire sram_req_t data_sram,
    output logic           data_addr_ok,
    output logic           data_data_ok,
    output data_t          data_rdata,

    // AXI master
    output axi_a_t         ar,
    output logic           arvalid,
    input  wire logic      arready,
    input  wire axi_r_t    r,
    input  wire logic      rvalid,
    output logic           rready,
    output axi_a_t         aw,
    output logic           awvalid,
    input  wire logic      awready,
    output axi_w_t         w,
    output logic           wvalid,
    input  wire logic      wready,
    input  wire logic      bvalid,
    output logic           bready
);

    logic  dread_req;
    logic  dread_ok;
    logic  dread_done;
    logic  dwrite_req;
    logic  dwrite_ok;
    logic  dwrite_done;
    data_t rdata_q;

    // both ports see the same registered read beat
    assign inst_rdata = rdata_q;
    assign data_rdata = rdata_q;

    sram_port_mux u_port_mux (
        .clk          (clk),
        .resetn       (resetn),
        .data_req     (data_req),
        .data_wr      (data_sram.wr),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .dread_req    (dread_req),
        .dread_ok     (dread_ok),
        .dread_done   (dread_done),
        .dwrite_req   (dwrite_req),
        .dwrite_ok    (dwrite_ok),
        .dwrite_done  (dwrite_done)
    );

    axi_read_path u_read_path (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_sram.addr),
        .inst_size    (inst_sram.size),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .dread_req    (dread_req),
        .data_sram    (data_sram),
        .dread_ok     (dread_ok),
        .dread_done   (dread_done),
        .rdata_q      (rdata_q),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    axi_write_path u_write_path (
        .clk          (clk),
        .resetn       (resetn),
        .dwrite_req   (dwrite_req),
        .data_sram    (data_sram),
        .dwrite_ok    (dwrite_ok),
        .dwrite_done  (dwrite_done),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready)
    );

endmodule

`default_nettype wire

/* bridge/axi_write_path.sv */
`default_nettype none

module axi_write_path
    import bridge_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      resetn,

    input  wire logic      dwrite_req,
    input  wire sram_req_t data_sram,
    output logic           dwrite_ok,
    output logic           dwrite_done,

    output axi_a_t         aw,
    output logic           awvalid,
    input  wire logic      awready,
    output axi_w_t         w,
    output logic           wvalid,
    input  wire logic      wready,
    input  wire logic      bvalid,
    output logic           bready
);

    wr_state_t state_q;
    logic      aw_pend_q;
    logic      w_pend_q;
    logic      done_q;
    axi_a_t    aw_q;
    axi_w_t    w_q;
    logic      aw_clear;
    logic      w_clear;

    assign dwrite_ok = dwrite_req && state_q == WR_IDLE;

    assign aw      = aw_q;
    assign w       = w_q;
    assign awvalid = aw_pend_q;
    assign wvalid  = w_pend_q;

    // no B can come back while AW or W is still pending
    assign bready = state_q != WR_SEND;

    // channel done either earlier or in this cycle
    assign aw_clear = !aw_pend_q || awready;
    assign w_clear  = !w_pend_q || wready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q   <= WR_IDLE;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                WR_IDLE: begin
                    if (dwrite_ok) begin
                        state_q   <= WR_SEND;
                        aw_pend_q <= 1'b1;
                        w_pend_q  <= 1'b1;
                    end
                end
                WR_SEND: begin
                    if (awready) begin
                        aw_pend_q <= 1'b0;
                    end
                    if (wready) begin
                        w_pend_q <= 1'b0;
                    end
                    if (aw_clear && w_clear) begin
                        state_q <= WR_WAIT_B;
                    end
                end
                WR_WAIT_B: begin
                    if (bvalid) begin
                        state_q <= WR_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: begin
                    state_q <= WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dwrite_ok) begin
            aw_q <= '{id: ID_DATA, addr: data_sram.addr, size: {1'b0, data_sram.size}};
            w_q  <= '{data: data_sram.wdata, strb: data_sram.wstrb};
        end
    end

    assign dwrite_done = done_q;

endmodule

`default_nettype wire

/* bridge/axi_read_path.sv */
`default_nettype none

module axi_read_path
    import bridge_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      resetn,

    input  wire logic      inst_req,
    input  wire addr_t     inst_addr,
    input  wire size_t     inst_size,
    output logic           inst_addr_ok,
    output logic           inst_data_ok,

    input  wire logic      dread_req,
    input  wire sram_req_t data_sram,
    output logic           dread_ok,
    output logic           dread_done,

    output data_t          rdata_q,

    output axi_a_t         ar,
    output logic           arvalid,
    input  wire logic      arready,
    input  wire axi_r_t    r,
    input  wire logic      rvalid,
    output logic           rready
);

    rd_state_t state_q;
    logic      inst_pend_q;
    axi_a_t    ar_q;
    axi_a_t    dlat_q;
    logic      dlat_valid_q;
    logic      rbeat_q;
    axi_id_t   rid_q;
    axi_a_t    inst_beat;
    axi_a_t    data_beat;

    assign inst_beat = '{id: ID_INST, addr: inst_addr, size: {1'b0, inst_size}};
    assign data_beat = '{id: ID_DATA, addr: data_sram.addr, size: {1'b0, data_sram.size}};

    // only one instruction read may be in flight
    assign inst_addr_ok = inst_req && state_q == RD_IDLE && !inst_pend_q;
    assign dread_ok     = dread_req && state_q == RD_IDLE;

    assign ar      = ar_q;
    assign arvalid = state_q != RD_IDLE;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q      <= RD_IDLE;
            dlat_valid_q <= 1'b0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (inst_addr_ok) begin
                        state_q <= RD_SEND_INST;
                        // data read in the same cycle waits behind it
                        dlat_valid_q <= dread_ok;
                    end else if (dread_ok) begin
                        state_q <= RD_SEND_DATA;
                    end
                end
                RD_SEND_INST: begin
                    if (arready) begin
                        state_q      <= dlat_valid_q ? RD_SEND_DATA : RD_IDLE;
                        dlat_valid_q <= 1'b0;
                    end
                end
                RD_SEND_DATA: begin
                    if (arready) begin
                        state_q <= RD_IDLE;
                    end
                end
                default: begin
                    state_q <= RD_IDLE;
                end
            endcase
        end
    end

    // AR payload only moves on accept or after an AR handshake
    always_ff @(posedge clk) begin
        if (inst_addr_ok) begin
            ar_q <= inst_beat;
        end else if (dread_ok) begin
            ar_q <= data_beat;
        end else if (state_q == RD_SEND_INST && arready && dlat_valid_q) begin
            ar_q <= dlat_q;
        end
        if (inst_addr_ok && dread_ok) begin
            dlat_q <= data_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_pend_q <= 1'b0;
        end else if (inst_addr_ok) begin
            inst_pend_q <= 1'b1;
        end else if (inst_data_ok) begin
            inst_pend_q <= 1'b0;
        end
    end

    // R beat registered, done pulse one cycle after the handshake
    assign rready = !rbeat_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rbeat_q <= 1'b0;
        end else begin
            rbeat_q <= rvalid && rready;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            rdata_q <= r.data;
            rid_q   <= r.id;
        end
    end

    // ID picks the port
    assign inst_data_ok = rbeat_q && rid_q == ID_INST;
    assign dread_done   = rbeat_q && rid_q == ID_DATA;

endmodule

`default_nettype wire

/* logic/sram_port_mux.sv */
`default_nettype none

module sram_port_mux (
    input  wire logic clk,
    input  wire logic resetn,

    input  wire logic data_req,
    input  wire logic data_wr,
    output logic      data_addr_ok,
    output logic      data_data_ok,

    output logic      dread_req,
    input  wire logic dread_ok,
    input  wire logic dread_done,

    output logic      dwrite_req,
    input  wire logic dwrite_ok,
    input  wire logic dwrite_done
);

    // one data transaction outstanding at a time
    logic busy_q;

    // steer by wr, nothing goes out while busy
    assign dread_req  = data_req && !data_wr && !busy_q;
    assign dwrite_req = data_req && data_wr && !busy_q;

    // only the selected path can accept
    assign data_addr_ok = dread_ok || dwrite_ok;

    // at most one of these per transaction
    assign data_data_ok = dread_done || dwrite_done;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
        end else if (data_addr_ok) begin
            busy_q <= 1'b1;
        end else if (data_data_ok) begin
            busy_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* common/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int ID_W       = 4;
    localparam int SIZE_W     = 2;
    localparam int AXI_SIZE_W = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [ID_W-1:0]   axi_id_t;
    typedef logic [SIZE_W-1:0] size_t;

    // read IDs, one per port
    localparam axi_id_t ID_INST = axi_id_t'(0);
    localparam axi_id_t ID_DATA = axi_id_t'(1);

    // request as seen on an SRAM-like port
    typedef struct packed {
        logic  wr;
        size_t size;
        strb_t wstrb;
        addr_t addr;
        data_t wdata;
    } sram_req_t;

    // shared by AR and AW
    typedef struct packed {
        axi_id_t               id;
        addr_t                 addr;
        logic [AXI_SIZE_W-1:0] size;
    } axi_a_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axi_w_t;

    typedef struct packed {
        axi_id_t id;
        data_t   data;
    } axi_r_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_SEND_INST,
        RD_SEND_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_WAIT_B
    } wr_state_t;

endpackage

`default_nettype wire
